// ==== Makefile ====
VERILATOR ?= verilator

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f rv_core.f --top-module rv_core_tb -o rv_core_sim
	out=$$(./obj_dir/rv_core_sim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// ==== logic/rv_core.sv ====
`include "rv_core_cfg.svh"

module rv_core (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`RV_XLEN-1:0]       insn,
  output logic [`RV_XLEN-1:0]       pc,
  output logic                      halt,
  output logic                      illegal,
  output logic                      wb_en,
  output logic [`RV_REG_IDX_W-1:0]  wb_rd,
  output logic [`RV_XLEN-1:0]       wb_data
);

  logic [`RV_REG_IDX_W-1:0]  rs1;
  logic [`RV_REG_IDX_W-1:0]  rs2;
  logic [`RV_REG_IDX_W-1:0]  rd;
  logic [`RV_XLEN-1:0]       imm;
  logic [`RV_XLEN-1:0]       rs1_data;
  logic [`RV_XLEN-1:0]       rs2_data;
  logic [`RV_XLEN-1:0]       next_pc;
  rv_core_pkg::alu_op_e      alu_op;
  rv_core_pkg::wb_sel_e      wb_sel;
  rv_core_pkg::branch_cond_e br_cond;
  logic                      alu_src_imm;
  logic                      reg_write;
  logic                      is_branch;
  logic                      is_jal;
  logic                      is_jalr;
  logic                      stop;
  logic                      bad_insn;
  logic                      running;

  assign running = !halt && !rst; // Blocks retire during reset and halt
  assign wb_rd   = rd;

  rv_fetch fetch0 (
    .clk(clk), .rst(rst), .next_pc(next_pc), .stop(stop), .bad_insn(bad_insn),
    .pc(pc), .halt(halt), .illegal(illegal)
  );

  rv_decode decode0 (
    .insn(insn), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .alu_src_imm(alu_src_imm), .wb_sel(wb_sel), .reg_write(reg_write),
    .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .br_cond(br_cond),
    .stop(stop), .bad_insn(bad_insn)
  );

  rv_regfile regfile0 (
    .clk(clk), .rst(rst), .we(wb_en), .rd(rd), .rd_data(wb_data),
    .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv_execute execute0 (
    .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
    .alu_op(alu_op), .alu_src_imm(alu_src_imm), .wb_sel(wb_sel), .reg_write(reg_write),
    .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr), .br_cond(br_cond),
    .running(running), .wb_en(wb_en), .wb_data(wb_data), .next_pc(next_pc)
  );

endmodule

// ==== logic/rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// One machine word, used for data and addresses
`define RV_XLEN 32

`define RV_NUM_REGS 32
`define RV_REG_IDX_W 5

// Fetch starts here after reset
`define RV_RESET_PC 32'h0000_0000
`define RV_PC_STEP 4 // Bytes per instruction

`endif

// ==== logic/rv_core_pkg.sv ====
`include "rv_core_cfg.svh"

package rv_core_pkg;

  // Major opcodes, ISA encodings
  typedef enum logic [6:0] {
    OP_LUI      = 7'b0110111,
    OP_AUIPC    = 7'b0010111,
    OP_JAL      = 7'b1101111,
    OP_JALR     = 7'b1100111,
    OP_BRANCH   = 7'b1100011,
    OP_REG_IMM  = 7'b0010011,
    OP_REG_REG  = 7'b0110011,
    OP_MISC_MEM = 7'b0001111,
    OP_ENVIRON  = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,    // ALU result
    WB_IMM,    // LUI
    WB_PC_IMM, // AUIPC
    WB_LINK    // Return address
  } wb_sel_e;

  typedef enum logic [0:0] {
    RUN    = 1'b0,
    HALTED = 1'b1
  } run_state_e;

  // Values follow funct3 of the branch group
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_cond_e;

endpackage

// ==== logic/rv_decode.sv ====
`include "rv_core_cfg.svh"

module rv_decode (
  input  logic [`RV_XLEN-1:0]        insn,
  output logic [`RV_REG_IDX_W-1:0]   rs1,
  output logic [`RV_REG_IDX_W-1:0]   rs2,
  output logic [`RV_REG_IDX_W-1:0]   rd,
  output logic [`RV_XLEN-1:0]        imm,
  output rv_core_pkg::alu_op_e       alu_op,
  output logic                       alu_src_imm,
  output rv_core_pkg::wb_sel_e       wb_sel,
  output logic                       reg_write,
  output logic                       is_branch,
  output logic                       is_jal,
  output logic                       is_jalr,
  output rv_core_pkg::branch_cond_e  br_cond,
  output logic                       stop,
  output logic                       bad_insn
);

  rv_core_pkg::opcode_e opcode;
  rv_core_pkg::alu_op_e arith_op; // funct3 mapping shared by both ALU formats
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic                 arith_alt;
  logic                 shift_f7_ok;
  logic                 reg_f7_ok;
  logic                 is_ecall;
  logic [`RV_XLEN-1:0]  imm_i;
  logic [`RV_XLEN-1:0]  imm_b;
  logic [`RV_XLEN-1:0]  imm_j;
  logic [`RV_XLEN-1:0]  imm_u;

  assign opcode = rv_core_pkg::opcode_e'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // Sign-extended immediates
  assign imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_b = {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{(`RV_XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign arith_alt   = (funct7 == 7'b0100000);
  assign shift_f7_ok = (funct7 == 7'd0) || (arith_alt && funct3 == 3'b101);
  assign reg_f7_ok   = (funct7 == 7'd0) || (arith_alt && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    case (funct3)
      3'b000:  arith_op = arith_alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  arith_op = rv_core_pkg::ALU_SLL;
      3'b010:  arith_op = rv_core_pkg::ALU_SLT;
      3'b011:  arith_op = rv_core_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_core_pkg::ALU_XOR;
      3'b101:  arith_op = arith_alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  arith_op = rv_core_pkg::ALU_OR;
      default: arith_op = rv_core_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    imm         = imm_i;
    alu_op      = rv_core_pkg::ALU_ADD;
    alu_src_imm = 1'b0;
    wb_sel      = rv_core_pkg::WB_ALU;
    reg_write   = 1'b0;
    is_branch   = 1'b0;
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    is_ecall    = 1'b0;
    bad_insn    = 1'b0;
    case (opcode)
      rv_core_pkg::OP_LUI: begin
        imm       = imm_u;
        wb_sel    = rv_core_pkg::WB_IMM;
        reg_write = 1'b1;
      end
      rv_core_pkg::OP_AUIPC: begin
        imm       = imm_u;
        wb_sel    = rv_core_pkg::WB_PC_IMM;
        reg_write = 1'b1;
      end
      rv_core_pkg::OP_JAL: begin
        imm       = imm_j;
        wb_sel    = rv_core_pkg::WB_LINK;
        reg_write = 1'b1;
        is_jal    = 1'b1;
      end
      rv_core_pkg::OP_JALR: begin
        // Target comes out of the ALU as rs1 + imm
        alu_src_imm = 1'b1;
        wb_sel      = rv_core_pkg::WB_LINK;
        reg_write   = (funct3 == 3'b000);
        is_jalr     = (funct3 == 3'b000);
        bad_insn    = (funct3 != 3'b000);
      end
      rv_core_pkg::OP_BRANCH: begin
        imm       = imm_b;
        is_branch = (funct3[2:1] != 2'b01);
        bad_insn  = (funct3[2:1] == 2'b01); // funct3 010 and 011 unused
      end
      rv_core_pkg::OP_REG_IMM: begin
        alu_src_imm = 1'b1;
        alu_op      = (funct3 == 3'b000) ? rv_core_pkg::ALU_ADD : arith_op;
        if (funct3[1:0] == 2'b01 && !shift_f7_ok) begin
          bad_insn = 1'b1; // Bad shift encoding
        end else begin
          reg_write = 1'b1;
        end
      end
      rv_core_pkg::OP_REG_REG: begin
        alu_op    = arith_op;
        reg_write = reg_f7_ok;
        bad_insn  = !reg_f7_ok;
      end
      rv_core_pkg::OP_MISC_MEM: bad_insn = (funct3 != 3'b000); // FENCE does nothing
      rv_core_pkg::OP_ENVIRON: begin
        is_ecall = (insn[31:7] == '0);
        bad_insn = (insn[31:7] != '0);
      end
      default: bad_insn = 1'b1;
    endcase
  end

  assign br_cond = rv_core_pkg::branch_cond_e'(funct3);
  assign stop    = is_ecall | bad_insn;

endmodule

// ==== logic/rv_execute.sv ====
`include "rv_core_cfg.svh"

module rv_execute (
  input  logic [`RV_XLEN-1:0]        pc,
  input  logic [`RV_XLEN-1:0]        rs1_data,
  input  logic [`RV_XLEN-1:0]        rs2_data,
  input  logic [`RV_XLEN-1:0]        imm,
  input  rv_core_pkg::alu_op_e       alu_op,
  input  logic                       alu_src_imm,
  input  rv_core_pkg::wb_sel_e       wb_sel,
  input  logic                       reg_write,
  input  logic                       is_branch,
  input  logic                       is_jal,
  input  logic                       is_jalr,
  input  rv_core_pkg::branch_cond_e  br_cond,
  input  logic                       running,
  output logic                       wb_en,
  output logic [`RV_XLEN-1:0]        wb_data,
  output logic [`RV_XLEN-1:0]        next_pc
);

  localparam int shamt_w = $clog2(`RV_XLEN);

  logic [`RV_XLEN-1:0] op_b;
  logic [shamt_w-1:0]  shamt;
  logic [`RV_XLEN-1:0] alu_res;
  logic [`RV_XLEN-1:0] seq_pc;
  logic [`RV_XLEN-1:0] rel_pc;    // pc + imm
  logic                eq;
  logic                lt_s;
  logic                lt_u;
  logic                taken;

  assign op_b  = alu_src_imm ? imm : rs2_data;
  assign shamt = op_b[shamt_w-1:0];

  // Single comparator, serves SLT/SLTU and the branches (op_b is rs2 there)
  assign eq   = (rs1_data == op_b);
  assign lt_s = ($signed(rs1_data) < $signed(op_b));
  assign lt_u = (rs1_data < op_b);

  always_comb begin
    case (alu_op)
      rv_core_pkg::ALU_ADD:  alu_res = rs1_data + op_b;
      rv_core_pkg::ALU_SUB:  alu_res = rs1_data - op_b;
      rv_core_pkg::ALU_SLL:  alu_res = rs1_data << shamt;
      rv_core_pkg::ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, lt_s};
      rv_core_pkg::ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, lt_u};
      rv_core_pkg::ALU_XOR:  alu_res = rs1_data ^ op_b;
      rv_core_pkg::ALU_SRL:  alu_res = rs1_data >> shamt;
      rv_core_pkg::ALU_SRA:  alu_res = $unsigned($signed(rs1_data) >>> shamt);
      rv_core_pkg::ALU_OR:   alu_res = rs1_data | op_b;
      rv_core_pkg::ALU_AND:  alu_res = rs1_data & op_b;
      default:               alu_res = '0;
    endcase
  end

  always_comb begin
    case (br_cond)
      rv_core_pkg::BR_EQ:  taken = eq;
      rv_core_pkg::BR_NE:  taken = !eq;
      rv_core_pkg::BR_LT:  taken = lt_s;
      rv_core_pkg::BR_GE:  taken = !lt_s;
      rv_core_pkg::BR_LTU: taken = lt_u;
      rv_core_pkg::BR_GEU: taken = !lt_u;
      default:             taken = 1'b0;
    endcase
  end

  assign seq_pc = pc + `RV_XLEN'(`RV_PC_STEP);
  assign rel_pc = pc + imm;

  always_comb begin
    if (is_jalr) begin
      next_pc = {alu_res[`RV_XLEN-1:1], 1'b0}; // Low bit cleared
    end else if (is_jal || (is_branch && taken)) begin
      next_pc = rel_pc;
    end else begin
      next_pc = seq_pc;
    end
  end

  always_comb begin
    case (wb_sel)
      rv_core_pkg::WB_IMM:    wb_data = imm;
      rv_core_pkg::WB_PC_IMM: wb_data = rel_pc;
      rv_core_pkg::WB_LINK:   wb_data = seq_pc;
      default:                wb_data = alu_res;
    endcase
  end

  assign wb_en = reg_write & running;

endmodule

// ==== logic/rv_fetch.sv ====
`include "rv_core_cfg.svh"

module rv_fetch (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`RV_XLEN-1:0]  next_pc,
  input  logic                 stop,
  input  logic                 bad_insn,
  output logic [`RV_XLEN-1:0]  pc,
  output logic                 halt,
  output logic                 illegal
);

  rv_core_pkg::run_state_e state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= rv_core_pkg::RUN;
      pc      <= `RV_RESET_PC;
      illegal <= 1'b0;
    end else if (state == rv_core_pkg::RUN) begin
      if (stop) begin
        // PC freezes on the stopping instruction
        state   <= rv_core_pkg::HALTED;
        illegal <= bad_insn;
      end else begin
        pc <= next_pc;
      end
    end
  end

  // Sticky until the next reset
  assign halt = (state == rv_core_pkg::HALTED);

endmodule

// ==== logic/rv_regfile.sv ====
`include "rv_core_cfg.svh"

module rv_regfile (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      we,
  input  logic [`RV_REG_IDX_W-1:0]  rd,
  input  logic [`RV_XLEN-1:0]       rd_data,
  input  logic [`RV_REG_IDX_W-1:0]  rs1,
  input  logic [`RV_REG_IDX_W-1:0]  rs2,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data
);

  // No storage for x0
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // Asynchronous reads, x0 forced to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== rv_core.f ====
+incdir+logic
logic/rv_core_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_core.sv
tests/rv_core_assertions.sv
tests/rv_core_tb.sv

// ==== tests/rv_core_assertions.sv ====
`include "rv_core_cfg.svh"

module rv_core_assertions (
  input logic                clk,
  input logic                rst,
  input logic [`RV_XLEN-1:0] pc,
  input logic [`RV_XLEN-1:0] rs1_data,
  input logic [`RV_XLEN-1:0] imm,
  input logic                halt,
  input logic                illegal,
  input logic                wb_en,
  input logic                stop,
  input logic                bad_insn,
  input logic                is_branch,
  input logic                is_jal,
  input logic                is_jalr
);
  timeunit 1ns;
  timeprecision 100ps;

  int   fail_count = 0;
  logic straight;

  // Running and no control transfer
  assign straight = !rst && !halt && !stop && !is_branch && !is_jal && !is_jalr;

  reset_state: assert property (@(posedge clk)
    rst |=> pc == `RV_RESET_PC && !halt && !illegal)
    else begin
      $error("Core state was not cleared by reset");
      fail_count++;
    end

  retire_blocked: assert property (@(posedge clk) (rst || halt) |-> !wb_en)
    else begin
      $error("Register write retired during reset or halt");
      fail_count++;
    end

  seq_flow: assert property (@(posedge clk) straight |=> pc == $past(pc) + `RV_PC_STEP)
    else begin
      $error("pc did not step by one instruction");
      fail_count++;
    end

  pc_aligned: assert property (@(posedge clk) !rst |-> pc[1:0] == 2'b00)
    else begin
      $error("pc is not word aligned");
      fail_count++;
    end

  // Target is rs1 plus offset with bit 0 dropped
  jalr_target: assert property (@(posedge clk)
    !rst && !halt && is_jalr |=> pc == (($past(rs1_data) + $past(imm)) & ~32'd1))
    else begin
      $error("JALR did not reach its target with the low bit cleared");
      fail_count++;
    end

  halt_entry: assert property (@(posedge clk)
    !rst && !halt && stop |=> halt && illegal == $past(bad_insn))
    else begin
      $error("Core did not halt with the right illegal flag");
      fail_count++;
    end

  halt_hold: assert property (@(posedge clk) !rst && halt |=> halt && pc == $past(pc))
    else begin
      $error("Halted core left halt or moved its pc");
      fail_count++;
    end

  illegal_hold: assert property (@(posedge clk) !rst && illegal |=> illegal && halt)
    else begin
      $error("Illegal flag dropped before reset");
      fail_count++;
    end

endmodule

// ==== tests/rv_core_tb.sv ====
`include "rv_core_cfg.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 16;
  localparam int mem_words    = 128; // Indexed by pc[8:2]

  logic                      clk;
  logic                      rst;
  logic [`RV_XLEN-1:0]       insn;
  logic [`RV_XLEN-1:0]       pc;
  logic                      halt;
  logic                      illegal;
  logic                      wb_en;
  logic [`RV_REG_IDX_W-1:0]  wb_rd;
  logic [`RV_XLEN-1:0]       wb_data;

  logic [31:0] prog [mem_words];
  logic [31:0] exp_data [mem_words]; // Expected retire port, by word address
  logic [4:0]  exp_rd [mem_words];
  logic        exp_write [mem_words];
  logic        exp_reach [mem_words];
  logic [31:0] model_regs [32];
  logic [31:0] model_pc;
  logic [31:0] ecall_pc;
  logic [31:0] bad_word;
  logic        bad_phase;           // Second run, undefined opcode everywhere
  int          errors;
  int          placed;
  int          limit_cycles;

  rv_core dut0 (.*);

  bind rv_core rv_core_assertions assertions0 (
    .clk(clk), .rst(rst), .pc(pc), .rs1_data(rs1_data), .imm(imm), .halt(halt),
    .illegal(illegal), .wb_en(wb_en), .stop(stop), .bad_insn(bad_insn),
    .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // Result of the OP and OP-IMM groups by funct3, alt selects SUB and SRA
  function automatic logic [31:0] alu_rule(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Stores one instruction at the model PC, then steps the model
  task automatic place(input logic [31:0] word, input logic wr, input logic [4:0] rd,
                       input logic [31:0] val, input logic [31:0] target);
    int idx;
    idx = int'(model_pc[31:2]);
    prog[idx]      = word;
    exp_reach[idx] = 1'b1;
    exp_write[idx] = wr;
    exp_rd[idx]    = rd;
    exp_data[idx]  = val;
    if (wr && rd != 5'd0) model_regs[rd] = val;
    model_pc = target;
    placed++;
  endtask

  task automatic put_imm(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [11:0] imm);
    logic [11:0] enc;
    enc = (f3[1:0] == 2'b01) ? {1'b0, alt, 5'b0, imm[4:0]} : imm; // Shifts keep shamt
    place({enc, rs1, f3, rd, 7'b0010011}, 1'b1, rd,
          alu_rule(f3, alt, model_regs[rs1], sext12(enc)), model_pc + 4);
  endtask

  task automatic put_reg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
    place({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011}, 1'b1, rd,
          alu_rule(f3, alt, model_regs[rs1], model_regs[rs2]), model_pc + 4);
  endtask

  task automatic put_upper(input logic auipc, input logic [4:0] rd, input logic [19:0] up);
    place({up, rd, auipc ? 7'b0010111 : 7'b0110111}, 1'b1, rd,
          {up, 12'b0} + (auipc ? model_pc : 32'd0), model_pc + 4);
  endtask

  // Offset of 8, a taken branch skips one slot
  task automatic put_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    place({7'b0, rs2, rs1, f3, 4'b0100, 1'b0, 7'b1100011}, 1'b0, 5'd0, 32'd0,
          branch_rule(f3, model_regs[rs1], model_regs[rs2]) ? model_pc + 8 : model_pc + 4);
  endtask

  task automatic put_jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
    place({imm, rs1, 3'b000, rd, 7'b1100111}, 1'b1, rd, model_pc + 4,
          (model_regs[rs1] + sext12(imm)) & ~32'd1);
  endtask

  task automatic build_program();
    logic [31:0] rnd;
    logic [2:0]  conds [6];
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    for (int i = 0; i < mem_words; i++) begin
      prog[i]      = {i[24:0], 7'b0000000}; // Opcode zero does not decode
      exp_reach[i] = 1'b0;
      exp_write[i] = 1'b0;
    end
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    model_pc = `RV_RESET_PC;
    for (int r = 1; r <= 8; r++) begin
      rnd = $urandom();
      put_upper(1'b0, 5'(r), rnd[31:12]);
      put_imm(3'd0, 1'b0, 5'(r), 5'(r), rnd[11:0]);
    end
    for (int f = 0; f < 8; f++) begin
      rnd = $urandom();
      put_imm(3'(f), 1'b0, 5'(f + 20), 5'(f + 1), rnd[11:0]);
      put_reg(3'(f), 1'b0, 5'(f + 10), 5'(f + 1), 5'((f + 3) % 8 + 1));
    end
    rnd = $urandom();
    put_imm(3'd5, 1'b1, 5'd28, 5'd3, rnd[11:0]);   // SRAI
    put_reg(3'd0, 1'b1, 5'd18, 5'd4, 5'd7);        // SUB
    put_reg(3'd5, 1'b1, 5'd19, 5'd2, 5'd6);        // SRA
    put_imm(3'd0, 1'b0, 5'd0, 5'd1, rnd[23:12]);   // Lost write to x0
    put_reg(3'd0, 1'b0, 5'd29, 5'd0, 5'd2);
    put_upper(1'b1, 5'd30, rnd[31:12]);
    place(32'h0ff0_000f, 1'b0, 5'd0, 32'd0, model_pc + 4); // FENCE
    for (int c = 0; c < 6; c++) begin
      put_branch(conds[c], 5'd1, 5'd1);
      put_branch(conds[c], 5'd1, 5'd2);
      put_branch(conds[c], 5'd2, 5'd1);
    end
    place({1'b0, 10'd6, 1'b0, 8'd0, 5'd31, 7'b1101111}, 1'b1, 5'd31, model_pc + 4,
          model_pc + 12);                          // JAL over two slots
    put_upper(1'b1, 5'd5, 20'd0);
    put_jalr(5'd6, 5'd5, 12'd13);                  // Odd target, low bit dropped
    ecall_pc = model_pc;
    place(32'h0000_0073, 1'b0, 5'd0, 32'd0, model_pc);
  endtask

  always @(negedge clk) begin
    insn <= bad_phase ? bad_word : prog[pc[8:2]];
  end

  // Retire port against the table, sampled before the edge updates anything
  always @(posedge clk) begin
    if (!rst && !halt && !bad_phase) begin
      if (!exp_reach[pc[8:2]]) begin
        errors++;
        $display("Core fetched from pc %h, which the program never reaches", pc);
      end else begin
        compare_word("wb_en", 32'(wb_en), 32'(exp_write[pc[8:2]]));
        if (wb_en && exp_write[pc[8:2]]) begin
          compare_word("wb_rd", 32'(wb_rd), 32'(exp_rd[pc[8:2]]));
          compare_word("wb_data", wb_data, exp_data[pc[8:2]]);
        end
      end
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, the core never reached the expected halt",
             limit_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hf6f6_ac07));
    rst          = 1'b1;
    insn         = '0;
    bad_phase    = 1'b0;
    errors       = 0;
    placed       = 0;
    limit_cycles = 0;
    bad_word     = $urandom();
    bad_word[6:0] = 7'b1111111; // Undefined major opcode
    build_program();
    limit_cycles = 4 * placed + 2 * reset_cycles;
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    while (!halt) @(negedge clk);
    compare_word("pc", pc, ecall_pc);
    compare_word("illegal", 32'(illegal), 32'd0);
    prog[ecall_pc[8:2]] = prog[0]; // Writing instruction under the halted pc
    repeat (4) @(negedge clk);
    rst       = 1'b1;
    bad_phase = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    while (!halt) @(negedge clk);
    compare_word("pc", pc, `RV_RESET_PC);
    compare_word("illegal", 32'(illegal), 32'd1);
    repeat (4) @(negedge clk);
    $display("Run complete: %0d errors, %0d assertion failures", errors,
             dut0.assertions0.fail_count);
    if (errors == 0 && dut0.assertions0.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
